// ==== list.f ====
source/cache_cfg_pkg.sv
source/cache_bus_pkg.sv
source/bank_fifo.sv
source/cache_tag_store.sv
source/cache_data_store.sv
source/cache_bank_ctrl.sv
source/cache_bank.sv
test/tb_mem_model.sv
test/tb_cache_bank.sv

// ==== Bender.yml ====
package:
  name: cache_bank

sources:
  - source/cache_cfg_pkg.sv
  - source/cache_bus_pkg.sv
  - source/bank_fifo.sv
  - source/cache_tag_store.sv
  - source/cache_data_store.sv
  - source/cache_bank_ctrl.sv
  - source/cache_bank.sv
  - target: test
    files:
      - test/tb_mem_model.sv
      - test/tb_cache_bank.sv

// ==== test/tb_cache_bank.sv ====
`timescale 1ns/1ps

module tb_cache_bank;

    localparam int          CLK_PERIOD     = 100;
    localparam int          DIRECTED_TESTS = 10;
    localparam int          RANDOM_TESTS   = 200;
    localparam int          TEST_COUNT     = DIRECTED_TESTS + RANDOM_TESTS;
    localparam int          MAX_MEM_DELAY  = 8;
    localparam int          DRAIN_CYCLES   = 200;
    localparam logic [31:0] SEED           = 32'h7b0f342b;
    localparam int          TIMEOUT_CYCLES =
        TEST_COUNT * (MAX_MEM_DELAY + 12) + cache_cfg_pkg::LINE_COUNT + 20;

    typedef logic [cache_cfg_pkg::LINE_ADDR_BITS + cache_cfg_pkg::WORD_SEL_BITS - 1:0] word_addr_t;

    logic                      clk;
    logic                      reset;
    cache_bus_pkg::core_req_t  core_req;
    logic                      core_req_valid;
    logic                      core_req_ready;
    cache_bus_pkg::core_rsp_t  core_rsp;
    logic                      core_rsp_valid;
    logic                      core_rsp_ready;
    cache_bus_pkg::mem_req_t   mem_req;
    logic                      mem_req_valid;
    logic                      mem_req_ready;
    cache_bus_pkg::mem_rsp_t   mem_rsp;
    logic                      mem_rsp_valid;
    logic                      mem_rsp_ready;
    cache_bus_pkg::req_tag_t   next_tag;

    // shadow of the tag store and of memory
    logic                      shadow_valid [cache_cfg_pkg::LINE_COUNT];
    cache_cfg_pkg::tag_t       shadow_tag   [cache_cfg_pkg::LINE_COUNT];
    cache_cfg_pkg::word_t      shadow_mem   [word_addr_t];
    cache_bus_pkg::core_rsp_t  exp_rsp_q    [$];
    cache_bus_pkg::mem_req_t   exp_mreq_q   [$];

    cache_bank #(
        .CRSQ_DEPTH (4),
        .MREQ_DEPTH (4)
    ) i_dut (
        .clk            (clk),
        .reset          (reset),
        .core_req       (core_req),
        .core_req_valid (core_req_valid),
        .core_req_ready (core_req_ready),
        .core_rsp       (core_rsp),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp_ready (core_rsp_ready),
        .mem_req        (mem_req),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp        (mem_rsp),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_ready  (mem_rsp_ready)
    );

    tb_mem_model #(
        .MAX_DELAY (MAX_MEM_DELAY)
    ) i_mem (
        .clk           (clk),
        .reset         (reset),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rsp       (mem_rsp),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic report_error(string msg);
        $display("ERR time %0d ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic report_failure(string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic check_core_rsp(cache_bus_pkg::core_rsp_t got, cache_bus_pkg::core_rsp_t exp);
        if (got !== exp) begin
            report_error($sformatf("core rsp data %h tag %h, expected data %h tag %h",
                                   got.data, got.tag, exp.data, exp.tag));
        end
    endtask

    task automatic check_mem_req(cache_bus_pkg::mem_req_t got, cache_bus_pkg::mem_req_t exp);
        if (got !== exp) begin
            report_error($sformatf("mem req addr %h rw %b byteen %h data %h, expected %h %b %h %h",
                                   got.addr, got.rw, got.byteen, got.data,
                                   exp.addr, exp.rw, exp.byteen, exp.data));
        end
    endtask

    // valid outputs stay low and ready stays low while the sweep runs
    task automatic check_init_sweep();
        for (int c = 0; c < cache_cfg_pkg::LINE_COUNT; c++) begin
            if (core_req_ready !== 1'b0 || core_rsp_valid !== 1'b0
                    || mem_req_valid !== 1'b0 || mem_rsp_ready !== 1'b0) begin
                report_error($sformatf("cycle %0d of the init sweep: ready %b rsp %b req %b fill %b",
                                       c, core_req_ready, core_rsp_valid, mem_req_valid,
                                       mem_rsp_ready));
            end
            @(negedge clk);
        end
        if (core_req_ready !== 1'b1) begin
            report_error("core_req_ready not high after the init sweep");
        end
    endtask

    function automatic cache_cfg_pkg::word_t memory_word(cache_cfg_pkg::line_addr_t addr,
                                                         cache_cfg_pkg::word_sel_t word_sel);
        if (shadow_mem.exists({addr, word_sel})) begin
            return shadow_mem[{addr, word_sel}];
        end
        // untouched memory, same pattern as the memory model
        return {addr, 14'h0, word_sel} ^ 32'h3c5a96e1;
    endfunction

    // reference model, runs once per accepted request in acceptance order
    function automatic void predict_request(cache_bus_pkg::core_req_t req);
        cache_cfg_pkg::tag_t      line_tag;
        cache_cfg_pkg::index_t    index;
        cache_cfg_pkg::word_t     mem_word;
        cache_bus_pkg::core_rsp_t rsp;
        cache_bus_pkg::mem_req_t  mreq;
        {line_tag, index} = req.addr;
        mem_word  = memory_word(req.addr, req.word_sel);
        mreq      = '0;
        mreq.addr = req.addr;
        if (req.rw) begin
            for (int b = 0; b < cache_cfg_pkg::WORD_BYTES; b++) begin
                if (req.byteen[b]) begin
                    mem_word[8 * b +: 8] = req.data[8 * b +: 8];
                end
                mreq.byteen[int'(req.word_sel) * cache_cfg_pkg::WORD_BYTES + b] = req.byteen[b];
            end
            shadow_mem[{req.addr, req.word_sel}] = mem_word;
            mreq.rw   = 1'b1;
            mreq.data = {cache_cfg_pkg::WORDS_PER_LINE{req.data}};
            exp_mreq_q.push_back(mreq);
        end else begin
            // a read miss fills, a write never allocates
            if (!shadow_valid[index] || shadow_tag[index] != line_tag) begin
                exp_mreq_q.push_back(mreq);
                shadow_valid[index] = 1'b1;
                shadow_tag[index]   = line_tag;
            end
            rsp.data = mem_word;
            rsp.tag  = req.tag;
            exp_rsp_q.push_back(rsp);
        end
    endfunction

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_req(cache_cfg_pkg::line_addr_t addr, cache_cfg_pkg::word_sel_t word_sel,
                            logic rw, cache_cfg_pkg::byteen_t byteen, cache_cfg_pkg::word_t data);
        core_req.addr     = addr;
        core_req.word_sel = word_sel;
        core_req.rw       = rw;
        core_req.byteen   = byteen;
        core_req.data     = data;
        core_req.tag      = next_tag;
        next_tag          = next_tag + 1'b1;
        core_req_valid    = 1'b1;
        do begin
            @(posedge clk);
        end while (!core_req_ready);
        @(negedge clk);
        core_req_valid = 1'b0;
    endtask

    // compare process, handshakes sampled on the rising edge
    always @(posedge clk) begin
        if (!reset) begin
            if (core_req_valid && core_req_ready) begin
                predict_request(core_req);
            end
            if (core_rsp_valid && core_rsp_ready) begin
                if (exp_rsp_q.size() == 0) begin
                    report_failure("the bank sent a core response with no read outstanding");
                end else begin
                    check_core_rsp(core_rsp, exp_rsp_q.pop_front());
                end
            end
            if (mem_req_valid && mem_req_ready) begin
                if (exp_mreq_q.size() == 0) begin
                    report_failure("the bank sent a memory request that was not expected");
                end else begin
                    check_mem_req(mem_req, exp_mreq_q.pop_front());
                end
            end
        end
    end

    // response back-pressure
    always @(negedge clk) begin
        core_rsp_ready = ($urandom_range(0, 2) != 0);
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        report_failure($sformatf("the run timed out after %0d clock cycles", TIMEOUT_CYCLES));
    end

    initial begin
        void'($urandom(SEED));
        clk            = 1'b0;
        reset          = 1'b1;
        core_req       = '0;
        core_req_valid = 1'b0;
        core_rsp_ready = 1'b0;
        next_tag       = '0;
        foreach (shadow_valid[i]) begin
            shadow_valid[i] = 1'b0;
            shadow_tag[i]   = '0;
        end
        repeat (5) @(negedge clk);
        reset = 1'b0;

        check_init_sweep();

        // cold miss, then a hit in the same line
        send_req(16'h0045, 2'd0, 1'b0, 4'hf, 32'h0);
        send_req(16'h0045, 2'd1, 1'b0, 4'hf, 32'h0);
        // write-through, then read back the merged bytes
        send_req(16'h0045, 2'd2, 1'b1, 4'b0110, 32'hdeadbeef);
        send_req(16'h0045, 2'd2, 1'b0, 4'hf, 32'h0);
        // write to an uncached line, the read after it still misses
        send_req(16'h0089, 2'd3, 1'b1, 4'b1001, 32'h12345678);
        send_req(16'h0089, 2'd3, 1'b0, 4'hf, 32'h0);
        // index 0x0c with tags 3 and 4 evict each other
        send_req(16'h00cc, 2'd0, 1'b0, 4'hf, 32'h0);
        send_req(16'h010c, 2'd0, 1'b0, 4'hf, 32'h0);
        send_req(16'h00cc, 2'd1, 1'b0, 4'hf, 32'h0);
        send_req(16'h010c, 2'd1, 1'b0, 4'hf, 32'h0);

        // three tags over four indices, mostly back to back
        for (int n = 0; n < RANDOM_TESTS; n++) begin
            send_req({cache_cfg_pkg::tag_t'($urandom_range(0, 2) * 347),
                      cache_cfg_pkg::index_t'($urandom_range(0, 3) * 21)},
                     cache_cfg_pkg::word_sel_t'($urandom_range(0, 3)),
                     ($urandom_range(0, 2) == 0),
                     cache_cfg_pkg::byteen_t'($urandom_range(1, 15)),
                     $urandom);
            if ($urandom_range(0, 3) == 0) begin
                repeat ($urandom_range(1, 3)) @(negedge clk);
            end
        end

        for (int c = 0; c < DRAIN_CYCLES; c++) begin
            @(negedge clk);
            if (exp_rsp_q.size() == 0 && exp_mreq_q.size() == 0) begin
                break;
            end
        end
        // stray extra traffic would show up here
        repeat (10) @(negedge clk);
        if (exp_rsp_q.size() != 0 || exp_mreq_q.size() != 0) begin
            report_failure($sformatf("%0d core responses and %0d memory requests never arrived",
                                     exp_rsp_q.size(), exp_mreq_q.size()));
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

// ==== test/tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model #(
    parameter int MAX_DELAY = 8
) (
    input  logic                     clk,
    input  logic                     reset,
    input  cache_bus_pkg::mem_req_t  mem_req,
    input  logic                     mem_req_valid,
    output logic                     mem_req_ready,
    output cache_bus_pkg::mem_rsp_t  mem_rsp,
    output logic                     mem_rsp_valid,
    input  logic                     mem_rsp_ready
);

    // only written lines are stored, the rest follow an address pattern
    cache_cfg_pkg::line_t store [cache_cfg_pkg::line_addr_t];
    cache_cfg_pkg::line_t work_line;
    cache_cfg_pkg::line_t pending_line;
    logic                 read_pending;
    int                   delay_left;

    function automatic cache_cfg_pkg::line_t line_at(cache_cfg_pkg::line_addr_t addr);
        cache_cfg_pkg::line_t line;
        if (store.exists(addr)) begin
            return store[addr];
        end
        for (int w = 0; w < cache_cfg_pkg::WORDS_PER_LINE; w++) begin
            line[cache_cfg_pkg::WORD_BITS * w +: cache_cfg_pkg::WORD_BITS] =
                {addr, 14'h0, 2'(w)} ^ 32'h3c5a96e1;
        end
        return line;
    endfunction

    initial begin
        mem_req_ready = 1'b0;
        mem_rsp       = '0;
        mem_rsp_valid = 1'b0;
        read_pending  = 1'b0;
        delay_left    = 0;
    end

    // handshakes are taken on the rising edge
    always @(posedge clk) begin
        if (reset) begin
            read_pending = 1'b0;
        end else begin
            if (mem_rsp_valid && mem_rsp_ready) begin
                read_pending = 1'b0;
            end
            if (mem_req_valid && mem_req_ready) begin
                work_line = line_at(mem_req.addr);
                if (mem_req.rw) begin
                    for (int b = 0; b < cache_cfg_pkg::LINE_BYTES; b++) begin
                        if (mem_req.byteen[b]) begin
                            work_line[8 * b +: 8] = mem_req.data[8 * b +: 8];
                        end
                    end
                    store[mem_req.addr] = work_line;
                end else begin
                    // line is captured now, later writes queue behind this read
                    pending_line = work_line;
                    read_pending = 1'b1;
                    delay_left   = $urandom_range(1, MAX_DELAY);
                end
            end
        end
    end

    // outputs move on the falling edge only
    always @(negedge clk) begin
        mem_req_ready = ($urandom_range(0, 3) != 0);
        if (read_pending && delay_left <= 1) begin
            mem_rsp_valid = 1'b1;
            mem_rsp.data  = pending_line;
        end else begin
            mem_rsp_valid = 1'b0;
            if (read_pending) begin
                delay_left = delay_left - 1;
            end
        end
    end

endmodule

// ==== source/cache_bank.sv ====
`timescale 1ns/1ps

module cache_bank #(
    parameter int CRSQ_DEPTH = 4,
    parameter int MREQ_DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      reset,

    input  cache_bus_pkg::core_req_t  core_req,
    input  logic                      core_req_valid,
    output logic                      core_req_ready,

    output cache_bus_pkg::core_rsp_t  core_rsp,
    output logic                      core_rsp_valid,
    input  logic                      core_rsp_ready,

    output cache_bus_pkg::mem_req_t   mem_req,
    output logic                      mem_req_valid,
    input  logic                      mem_req_ready,

    input  cache_bus_pkg::mem_rsp_t   mem_rsp,
    input  logic                      mem_rsp_valid,
    output logic                      mem_rsp_ready
);

    logic                       tag_op_lookup;
    logic                       tag_op_fill;
    logic                       tag_op_clear;
    logic                       tag_hit;
    cache_cfg_pkg::line_addr_t  op_addr;

    logic                       data_read;
    logic                       data_write;
    logic                       data_fill;
    cache_cfg_pkg::word_sel_t   op_word_sel;
    cache_cfg_pkg::byteen_t     op_byteen;
    cache_cfg_pkg::word_t       op_word;
    cache_cfg_pkg::line_t       fill_line;
    cache_cfg_pkg::word_t       read_word;

    logic                       crsq_push;
    logic                       crsq_almost_full;
    cache_bus_pkg::core_rsp_t   crsq_item;
    logic                       mreq_push;
    logic                       mreq_almost_full;
    cache_bus_pkg::mem_req_t    mreq_item;

    cache_bank_ctrl i_ctrl (
        .clk              (clk),
        .reset            (reset),
        .core_req         (core_req),
        .core_req_valid   (core_req_valid),
        .mem_rsp          (mem_rsp),
        .mem_rsp_valid    (mem_rsp_valid),
        .tag_hit          (tag_hit),
        .read_word        (read_word),
        .crsq_almost_full (crsq_almost_full),
        .mreq_almost_full (mreq_almost_full),
        .core_req_ready   (core_req_ready),
        .mem_rsp_ready    (mem_rsp_ready),
        .tag_op_lookup    (tag_op_lookup),
        .tag_op_fill      (tag_op_fill),
        .tag_op_clear     (tag_op_clear),
        .op_addr          (op_addr),
        .data_read        (data_read),
        .data_write       (data_write),
        .data_fill        (data_fill),
        .op_word_sel      (op_word_sel),
        .op_byteen        (op_byteen),
        .op_word          (op_word),
        .fill_line        (fill_line),
        .crsq_push        (crsq_push),
        .crsq_item        (crsq_item),
        .mreq_push        (mreq_push),
        .mreq_item        (mreq_item)
    );

    cache_tag_store i_tag_store (
        .clk    (clk),
        .reset  (reset),
        .lookup (tag_op_lookup),
        .fill   (tag_op_fill),
        .clear  (tag_op_clear),
        .addr   (op_addr),
        .hit    (tag_hit)
    );

    cache_data_store i_data_store (
        .clk        (clk),
        .read       (data_read),
        .write      (data_write),
        .fill       (data_fill),
        .addr       (op_addr),
        .word_sel   (op_word_sel),
        .byteen     (op_byteen),
        .write_word (op_word),
        .fill_line  (fill_line),
        .read_word  (read_word)
    );

    // core response queue
    bank_fifo #(
        .DEPTH  (CRSQ_DEPTH),
        .item_t (cache_bus_pkg::core_rsp_t)
    ) crsq_fifo (
        .clk         (clk),
        .reset       (reset),
        .push        (crsq_push),
        .push_item   (crsq_item),
        .pop         (core_rsp_valid & core_rsp_ready),
        .head        (core_rsp),
        .not_empty   (core_rsp_valid),
        .almost_full (crsq_almost_full)
    );

    // memory request queue
    bank_fifo #(
        .DEPTH  (MREQ_DEPTH),
        .item_t (cache_bus_pkg::mem_req_t)
    ) mreq_fifo (
        .clk         (clk),
        .reset       (reset),
        .push        (mreq_push),
        .push_item   (mreq_item),
        .pop         (mem_req_valid & mem_req_ready),
        .head        (mem_req),
        .not_empty   (mem_req_valid),
        .almost_full (mreq_almost_full)
    );

endmodule

// ==== source/cache_bank_ctrl.sv ====
`timescale 1ns/1ps

module cache_bank_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    input  cache_bus_pkg::core_req_t   core_req,
    input  logic                       core_req_valid,
    input  cache_bus_pkg::mem_rsp_t    mem_rsp,
    input  logic                       mem_rsp_valid,
    input  logic                       tag_hit,
    input  cache_cfg_pkg::word_t       read_word,
    input  logic                       crsq_almost_full,
    input  logic                       mreq_almost_full,
    output logic                       core_req_ready,
    output logic                       mem_rsp_ready,
    output logic                       tag_op_lookup,
    output logic                       tag_op_fill,
    output logic                       tag_op_clear,
    output cache_cfg_pkg::line_addr_t  op_addr,
    output logic                       data_read,
    output logic                       data_write,
    output logic                       data_fill,
    output cache_cfg_pkg::word_sel_t   op_word_sel,
    output cache_cfg_pkg::byteen_t     op_byteen,
    output cache_cfg_pkg::word_t       op_word,
    output cache_cfg_pkg::line_t       fill_line,
    output logic                       crsq_push,
    output cache_bus_pkg::core_rsp_t   crsq_item,
    output logic                       mreq_push,
    output cache_bus_pkg::mem_req_t    mreq_item
);

    typedef enum logic [2:0] {
        ST_INIT,
        ST_RUN,
        ST_MISS_WAIT,
        ST_REPLAY_MISS,
        ST_REPLAY_HELD
    } state_t;

    state_t                    state;
    cache_cfg_pkg::index_t     sweep_idx;

    // stage 0 is being looked up, stage 1 has its lookup result
    cache_bus_pkg::core_req_t  st0_req;
    cache_bus_pkg::core_req_t  st1_req;
    cache_bus_pkg::core_req_t  op_req;
    logic                      st0_valid;
    logic                      st1_valid;

    logic                      req_fire;
    logic                      fill_fire;
    logic                      advance;
    logic                      write_block;
    logic                      st1_read;
    logic                      st1_write;
    logic                      result_valid;
    logic                      read_hit;
    logic                      read_miss;
    logic                      write_hit;
    logic                      write_thru;

    assign st1_read  = st1_valid && !st1_req.rw;
    assign st1_write = st1_valid && st1_req.rw;

    // tag_hit belongs to stage 1 only in these two states
    assign result_valid = (state == ST_RUN) || (state == ST_REPLAY_HELD);

    assign read_hit   = result_valid && st1_read && tag_hit;
    assign read_miss  = (state == ST_RUN) && st1_read && !tag_hit;
    assign write_hit  = (state == ST_RUN) && st1_write && tag_hit;
    assign write_thru = (state == ST_RUN) && st1_write;

    // no read in stage 0 while a write sits in stage 1
    assign write_block = st0_valid && st0_req.rw;

    assign core_req_ready = (state == ST_RUN) && !read_miss && !write_block
                            && !crsq_almost_full && !mreq_almost_full;
    assign req_fire       = core_req_valid && core_req_ready;

    assign mem_rsp_ready  = (state == ST_MISS_WAIT);
    assign fill_fire      = mem_rsp_valid && mem_rsp_ready;

    // both stages hold still from a miss until the replay of the held request
    assign advance = ((state == ST_RUN) && !read_miss) || (state == ST_REPLAY_HELD);

    // stage 1 owns the stores while it writes, misses or replays
    always_comb begin
        op_req = st0_req;
        if ((state != ST_RUN && state != ST_REPLAY_HELD) || st1_write) begin
            op_req = st1_req;
        end
    end

    assign op_addr     = (state == ST_INIT) ? cache_cfg_pkg::line_addr_t'(sweep_idx)
                                            : op_req.addr;
    assign op_word_sel = op_req.word_sel;
    assign op_byteen   = op_req.byteen;
    assign op_word     = op_req.data;
    assign fill_line   = mem_rsp.data;

    assign tag_op_clear  = (state == ST_INIT);
    assign tag_op_fill   = fill_fire;
    assign data_fill     = fill_fire;
    assign tag_op_lookup = (result_valid && st0_valid) || (state == ST_REPLAY_MISS);
    assign data_read     = tag_op_lookup && !op_req.rw;
    assign data_write    = write_hit;

    assign crsq_push      = read_hit;
    assign crsq_item.data = read_word;
    assign crsq_item.tag  = st1_req.tag;

    // write-through item carries the word in every slot, enables at its own slot
    assign mreq_push      = read_miss || write_thru;
    assign mreq_item.addr = st1_req.addr;
    assign mreq_item.rw   = st1_req.rw;
    assign mreq_item.byteen = st1_req.rw
        ? cache_cfg_pkg::line_byteen_t'(st1_req.byteen)
              << (int'(st1_req.word_sel) * cache_cfg_pkg::WORD_BYTES)
        : '0;
    assign mreq_item.data = st1_req.rw ? {cache_cfg_pkg::WORDS_PER_LINE{st1_req.data}} : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_INIT;
            sweep_idx <= '0;
            st0_valid <= 1'b0;
            st1_valid <= 1'b0;
        end else begin
            if (advance) begin
                st1_valid <= st0_valid;
                st0_valid <= req_fire;
            end
            case (state)
                ST_INIT: begin
                    sweep_idx <= sweep_idx + 1'b1;
                    if (sweep_idx == cache_cfg_pkg::index_t'(cache_cfg_pkg::LINE_COUNT - 1)) begin
                        state <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (read_miss) begin
                        state <= ST_MISS_WAIT;
                    end
                end
                ST_MISS_WAIT: begin
                    if (fill_fire) begin
                        state <= ST_REPLAY_MISS;
                    end
                end
                // missed read looks up again, then the held one
                ST_REPLAY_MISS: state <= ST_REPLAY_HELD;
                ST_REPLAY_HELD: state <= ST_RUN;
                default: state <= ST_INIT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            st1_req <= st0_req;
        end
        if (req_fire) begin
            st0_req <= core_req;
        end
    end

endmodule

// ==== source/cache_data_store.sv ====
`timescale 1ns/1ps

module cache_data_store (
    input  logic                       clk,
    input  logic                       read,
    input  logic                       write,
    input  logic                       fill,
    input  cache_cfg_pkg::line_addr_t  addr,
    input  cache_cfg_pkg::word_sel_t   word_sel,
    input  cache_cfg_pkg::byteen_t     byteen,
    input  cache_cfg_pkg::word_t       write_word,
    input  cache_cfg_pkg::line_t       fill_line,
    output cache_cfg_pkg::word_t       read_word
);

    localparam int WORD_BITS = cache_cfg_pkg::WORD_BITS;

    cache_cfg_pkg::line_t  lines [cache_cfg_pkg::LINE_COUNT];

    cache_cfg_pkg::index_t index;
    int                    word_lsb;

    assign index    = addr[cache_cfg_pkg::INDEX_BITS-1:0];
    assign word_lsb = int'(word_sel) * WORD_BITS;

    // a fill replaces the line, a write merges enabled bytes of one word
    always_ff @(posedge clk) begin
        if (fill) begin
            lines[index] <= fill_line;
        end else if (write) begin
            for (int b = 0; b < cache_cfg_pkg::WORD_BYTES; b++) begin
                if (byteen[b]) begin
                    lines[index][word_lsb + 8 * b +: 8] <= write_word[8 * b +: 8];
                end
            end
        end
    end

    // registered word read
    always_ff @(posedge clk) begin
        if (read) begin
            read_word <= lines[index][word_lsb +: WORD_BITS];
        end
    end

endmodule

// ==== source/cache_tag_store.sv ====
`timescale 1ns/1ps

module cache_tag_store (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       lookup,
    input  logic                       fill,
    input  logic                       clear,
    input  cache_cfg_pkg::line_addr_t  addr,
    output logic                       hit
);

    logic                  valid_bits [cache_cfg_pkg::LINE_COUNT];
    cache_cfg_pkg::tag_t   tags       [cache_cfg_pkg::LINE_COUNT];

    cache_cfg_pkg::index_t index;
    cache_cfg_pkg::tag_t   addr_tag;

    assign index    = addr[cache_cfg_pkg::INDEX_BITS-1:0];
    assign addr_tag = addr[cache_cfg_pkg::LINE_ADDR_BITS-1 -: cache_cfg_pkg::TAG_BITS];

    // valid bits are cleared by the init sweep
    always_ff @(posedge clk) begin
        if (fill) begin
            valid_bits[index] <= 1'b1;
        end else if (clear) begin
            valid_bits[index] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tags[index] <= addr_tag;
        end
    end

    // compare result is ready the cycle after the lookup
    always_ff @(posedge clk) begin
        if (reset) begin
            hit <= 1'b0;
        end else if (lookup) begin
            hit <= valid_bits[index] && (tags[index] == addr_tag);
        end
    end

endmodule

// ==== source/bank_fifo.sv ====
`timescale 1ns/1ps

module bank_fifo #(
    parameter int  DEPTH  = 4,
    parameter type item_t = logic [7:0]
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  push,
    input  item_t push_item,
    input  logic  pop,
    output item_t head,
    output logic  not_empty,
    output logic  almost_full
);

    localparam int PTR_BITS   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_BITS = $clog2(DEPTH + 1);

    item_t                 slots [DEPTH];
    logic [PTR_BITS-1:0]   rd_ptr;
    logic [PTR_BITS-1:0]   wr_ptr;
    logic [COUNT_BITS-1:0] count;

    assign head      = slots[rd_ptr];
    assign not_empty = (count != '0);

    // includes this cycle's push, so items already in the pipeline still fit
    assign almost_full = (int'(count) + int'(push)) > (DEPTH - 2);

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= push_item;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + COUNT_BITS'(push) - COUNT_BITS'(pop);
        end
    end

endmodule

// ==== source/cache_bus_pkg.sv ====
package cache_bus_pkg;

    // request id handed back with the read response
    typedef logic [7:0] req_tag_t;

    // core side request, one word per transfer
    typedef struct packed {
        cache_cfg_pkg::line_addr_t addr;
        cache_cfg_pkg::word_sel_t  word_sel;
        // 1 = write, 0 = read
        logic                      rw;
        cache_cfg_pkg::byteen_t    byteen;
        cache_cfg_pkg::word_t      data;
        req_tag_t                  tag;
    } core_req_t;

    // read responses only, writes get none
    typedef struct packed {
        cache_cfg_pkg::word_t data;
        req_tag_t             tag;
    } core_rsp_t;

    // line fill read or write-through store
    typedef struct packed {
        cache_cfg_pkg::line_addr_t   addr;
        logic                        rw;
        cache_cfg_pkg::line_byteen_t byteen;
        cache_cfg_pkg::line_t        data;
    } mem_req_t;

    // only one fill is ever outstanding, so no id
    typedef struct packed {
        cache_cfg_pkg::line_t data;
    } mem_rsp_t;

endpackage

// ==== source/cache_cfg_pkg.sv ====
package cache_cfg_pkg;

    // bank geometry
    localparam int WORD_BYTES     = 4;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_COUNT     = 64;

    // derived sizes
    localparam int WORD_BITS      = 8 * WORD_BYTES;
    localparam int LINE_BYTES     = WORD_BYTES * WORDS_PER_LINE;
    localparam int LINE_BITS      = 8 * LINE_BYTES;
    localparam int LINE_ADDR_BITS = 16;
    localparam int INDEX_BITS     = $clog2(LINE_COUNT);
    localparam int TAG_BITS       = LINE_ADDR_BITS - INDEX_BITS;
    localparam int WORD_SEL_BITS  = $clog2(WORDS_PER_LINE);

    // line address is {tag, index}
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [INDEX_BITS-1:0]     index_t;
    typedef logic [TAG_BITS-1:0]       tag_t;

    typedef logic [WORD_SEL_BITS-1:0]  word_sel_t;
    typedef logic [WORD_BYTES-1:0]     byteen_t;
    typedef logic [WORD_BITS-1:0]      word_t;

    // full line as seen on the memory side
    typedef logic [LINE_BITS-1:0]      line_t;
    typedef logic [LINE_BYTES-1:0]     line_byteen_t;

endpackage
